// ==== hw/mchan_ctrl_pkg.sv ====
// ********************************************************************
// Shared widths, register offsets, command layout and types of the
// DMA programming front end, referenced by package-scoped names
// ********************************************************************

package mchan_ctrl_pkg;

   localparam int unsigned NB_TRANSFERS   = 4;
   localparam int unsigned SID_WIDTH      = (NB_TRANSFERS == 1) ? 1 : $clog2(NB_TRANSFERS);
   localparam int unsigned LEN_WIDTH      = 16;
   localparam int unsigned TCDM_ADD_WIDTH = 12;
   localparam int unsigned EXT_ADD_WIDTH  = 29;
   localparam int unsigned PE_ID_WIDTH    = 1;
   localparam int unsigned OFFSET_WIDTH   = 4;

   localparam logic [OFFSET_WIDTH-1:0] CMD_OFFSET    = 4'h0;
   localparam logic [OFFSET_WIDTH-1:0] STATUS_OFFSET = 4'h4;

   // Command word layout, length in the low bits
   localparam int unsigned OPC_BIT = LEN_WIDTH;
   localparam int unsigned INC_BIT = LEN_WIDTH + 1;
   localparam int unsigned ELE_BIT = LEN_WIDTH + 3;
   localparam int unsigned ILE_BIT = LEN_WIDTH + 4;
   localparam int unsigned BLE_BIT = LEN_WIDTH + 5;

   localparam int unsigned ALLOC_STATUS_LSB = 16;   // Allocation bitmap in status word

   typedef enum logic [0:0] {
      OPC_TX = 1'b0,
      OPC_RX = 1'b1
   } mchan_opc_e;

   typedef enum logic [2:0] {
      OP_NONE,
      OP_SID_RD,
      OP_CMD_WR,
      OP_STATUS_RD,
      OP_CLEAR_WR
   } ctrl_op_e;

   typedef enum logic [3:0] {
      IDLE,
      STATUS_GRANTED,
      CLEAR_GRANTED,
      SID_GRANTED,
      CMD,
      CMD_GRANTED,
      TCDM,
      TCDM_GRANTED,
      EXT,
      EXT_GRANTED,
      BUSY_ARB,
      BUSY_DONE
   } seq_state_e;

   typedef enum logic [1:0] {
      RSP_NONE,
      RSP_ACK,
      RSP_SID,
      RSP_STATUS
   } rsp_kind_e;

   typedef struct packed {
      logic                   req;
      logic                   wen;    // High for write
      logic [31:0]            add;
      logic [31:0]            data;
      logic [PE_ID_WIDTH-1:0] id;
   } targ_req_t;

   typedef struct packed {
      logic                   r_valid;
      logic [31:0]            r_data;
      logic [PE_ID_WIDTH-1:0] r_id;
   } targ_rsp_t;

   typedef struct packed {
      logic [LEN_WIDTH-1:0] len;  // Length minus one
      mchan_opc_e           opc;
      logic                 inc;
      logic                 ele;
      logic                 ile;
      logic                 ble;
      logic [SID_WIDTH-1:0] sid;
   } cmd_t;

endpackage

// ==== hw/ctrl_decode.sv ====
// ********************************************************************
// Decode stage: classifies target requests by offset and direction
// and unpacks the command word, purely combinational
// ********************************************************************

`timescale 1ns/1ps

module ctrl_decode
(
   input  mchan_ctrl_pkg::targ_req_t                 targ_req_i,
   output mchan_ctrl_pkg::ctrl_op_e                  op_o,
   output mchan_ctrl_pkg::cmd_t                      cmd_fields_o,
   output logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0]   clr_mask_o
);

   logic [mchan_ctrl_pkg::OFFSET_WIDTH-1:0] offset;

   assign offset = targ_req_i.add[mchan_ctrl_pkg::OFFSET_WIDTH-1:0];

   // ******************************************************************
   // Request classification
   // ******************************************************************

   always_comb
   begin
      op_o = mchan_ctrl_pkg::OP_NONE;
      if (targ_req_i.req)
      begin
         case (offset)
            mchan_ctrl_pkg::CMD_OFFSET:
            begin
               op_o = targ_req_i.wen ? mchan_ctrl_pkg::OP_CMD_WR
                                     : mchan_ctrl_pkg::OP_SID_RD;
            end
            mchan_ctrl_pkg::STATUS_OFFSET:
            begin
               op_o = targ_req_i.wen ? mchan_ctrl_pkg::OP_CLEAR_WR
                                     : mchan_ctrl_pkg::OP_STATUS_RD;
            end
            default:
            begin
               op_o = mchan_ctrl_pkg::OP_NONE;  // Unmapped offset
            end
         endcase
      end
   end

   // ******************************************************************
   // Command word fields
   // ******************************************************************

   always_comb
   begin
      cmd_fields_o     = '0;
      cmd_fields_o.len = targ_req_i.data[mchan_ctrl_pkg::LEN_WIDTH-1:0]
                         - mchan_ctrl_pkg::LEN_WIDTH'(1);
      cmd_fields_o.opc = mchan_ctrl_pkg::mchan_opc_e'(targ_req_i.data[mchan_ctrl_pkg::OPC_BIT]);
      cmd_fields_o.inc = targ_req_i.data[mchan_ctrl_pkg::INC_BIT];   // Incremental
      cmd_fields_o.ele = targ_req_i.data[mchan_ctrl_pkg::ELE_BIT];   // Event lines
      cmd_fields_o.ile = targ_req_i.data[mchan_ctrl_pkg::ILE_BIT];   // Interrupt lines
      cmd_fields_o.ble = targ_req_i.data[mchan_ctrl_pkg::BLE_BIT];   // Broadcast
   end

   assign clr_mask_o = targ_req_i.data[mchan_ctrl_pkg::NB_TRANSFERS-1:0];

endmodule

// ==== hw/ctrl_sequencer.sv ====
// ********************************************************************
// Execute stage: programming FSM for ID read, command, TCDM and
// external writes, then the arbiter barrier and completion wait
// ********************************************************************

`timescale 1ns/1ps

module ctrl_sequencer
(
   input  logic                                      clk_i,
   input  logic                                      rst_ni,

   input  mchan_ctrl_pkg::ctrl_op_e                  op_i,
   input  logic                                      req_i,
   input  mchan_ctrl_pkg::cmd_t                      cmd_fields_i,
   input  logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0]   clr_mask_i,

   input  logic                                      cmd_gnt_i,
   output logic                                      cmd_req_o,
   input  logic                                      tcdm_gnt_i,
   output logic                                      tcdm_req_o,
   input  logic                                      ext_gnt_i,
   output logic                                      ext_req_o,

   output logic                                      trans_alloc_req_o,
   input  logic                                      trans_alloc_gnt_i,
   input  logic [mchan_ctrl_pkg::SID_WIDTH-1:0]      trans_alloc_ret_i,
   output logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0]   trans_alloc_clr_o,

   input  logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0]   trans_status_i,
   input  logic                                      arb_req_i,
   input  logic                                      arb_gnt_i,
   input  logic [mchan_ctrl_pkg::SID_WIDTH-1:0]      arb_sid_i,

   output logic                                      targ_gnt_o,
   output mchan_ctrl_pkg::rsp_kind_e                 rsp_kind_o,
   output logic [mchan_ctrl_pkg::SID_WIDTH-1:0]      sid_o,
   output mchan_ctrl_pkg::cmd_t                      cmd_o,
   output logic                                      busy_o
);

   mchan_ctrl_pkg::seq_state_e              state_q, state_d;
   logic [mchan_ctrl_pkg::SID_WIDTH-1:0]    sid_q;
   logic                                    barrier_q;
   logic                                    arb_match;
   logic                                    step_cmd, step_tcdm, step_ext;
   logic                                    step_gnt, cmd_wr, push;

   // Which queue the current write step feeds
   assign step_cmd  = state_q inside {mchan_ctrl_pkg::SID_GRANTED, mchan_ctrl_pkg::CMD};
   assign step_tcdm = state_q inside {mchan_ctrl_pkg::CMD_GRANTED, mchan_ctrl_pkg::TCDM};
   assign step_ext  = state_q inside {mchan_ctrl_pkg::TCDM_GRANTED, mchan_ctrl_pkg::EXT};

   assign step_gnt  = (step_cmd & cmd_gnt_i) | (step_tcdm & tcdm_gnt_i) | (step_ext & ext_gnt_i);
   assign cmd_wr    = (op_i == mchan_ctrl_pkg::OP_CMD_WR);
   assign push      = req_i & cmd_wr & step_gnt;

   assign cmd_req_o  = push & step_cmd;
   assign tcdm_req_o = push & step_tcdm;
   assign ext_req_o  = push & step_ext;

   assign arb_match = arb_req_i & arb_gnt_i & (arb_sid_i == sid_q);

   // ******************************************************************
   // Next state and grants
   // ******************************************************************

   always_comb
   begin
      state_d           = state_q;
      targ_gnt_o        = push;
      trans_alloc_req_o = 1'b0;
      trans_alloc_clr_o = '0;
      busy_o            = 1'b1;

      case (state_q)
         mchan_ctrl_pkg::IDLE:
         begin
            busy_o = req_i;
            case (op_i)
               mchan_ctrl_pkg::OP_STATUS_RD:
               begin
                  targ_gnt_o = 1'b1;
                  state_d    = mchan_ctrl_pkg::STATUS_GRANTED;
               end
               mchan_ctrl_pkg::OP_CLEAR_WR:
               begin
                  targ_gnt_o        = 1'b1;
                  trans_alloc_clr_o = clr_mask_i;
                  state_d           = mchan_ctrl_pkg::CLEAR_GRANTED;
               end
               mchan_ctrl_pkg::OP_SID_RD:
               begin
                  trans_alloc_req_o = 1'b1;
                  if (trans_alloc_gnt_i)
                  begin
                     targ_gnt_o = 1'b1;
                     state_d    = mchan_ctrl_pkg::SID_GRANTED;
                  end
               end
               default:
               begin
                  state_d = mchan_ctrl_pkg::IDLE;
               end
            endcase
         end

         mchan_ctrl_pkg::STATUS_GRANTED, mchan_ctrl_pkg::CLEAR_GRANTED:
         begin
            state_d = mchan_ctrl_pkg::IDLE;
         end

         mchan_ctrl_pkg::SID_GRANTED, mchan_ctrl_pkg::CMD,
         mchan_ctrl_pkg::CMD_GRANTED, mchan_ctrl_pkg::TCDM,
         mchan_ctrl_pkg::TCDM_GRANTED, mchan_ctrl_pkg::EXT:
         begin
            if (req_i && !cmd_wr)
               state_d = mchan_ctrl_pkg::IDLE;   // Sequence broken off
            else if (push)
               state_d = step_cmd  ? mchan_ctrl_pkg::CMD_GRANTED :
                         step_tcdm ? mchan_ctrl_pkg::TCDM_GRANTED :
                                     mchan_ctrl_pkg::EXT_GRANTED;
            else
               state_d = step_cmd  ? mchan_ctrl_pkg::CMD :
                         step_tcdm ? mchan_ctrl_pkg::TCDM :
                                     mchan_ctrl_pkg::EXT;
         end

         mchan_ctrl_pkg::EXT_GRANTED:
         begin
            state_d = mchan_ctrl_pkg::BUSY_ARB;
         end

         mchan_ctrl_pkg::BUSY_ARB:
         begin
            if (!barrier_q || arb_match)
               state_d = mchan_ctrl_pkg::BUSY_DONE;
         end

         mchan_ctrl_pkg::BUSY_DONE:
         begin
            if (trans_status_i[sid_q])
               state_d = mchan_ctrl_pkg::IDLE;   // Transfer completed
         end

         default:
         begin
            state_d = mchan_ctrl_pkg::IDLE;
         end
      endcase
   end

   // Response kind follows the granted state
   always_comb
   begin
      case (state_q)
         mchan_ctrl_pkg::STATUS_GRANTED: rsp_kind_o = mchan_ctrl_pkg::RSP_STATUS;
         mchan_ctrl_pkg::SID_GRANTED:    rsp_kind_o = mchan_ctrl_pkg::RSP_SID;
         mchan_ctrl_pkg::CLEAR_GRANTED,
         mchan_ctrl_pkg::CMD_GRANTED,
         mchan_ctrl_pkg::TCDM_GRANTED,
         mchan_ctrl_pkg::EXT_GRANTED:    rsp_kind_o = mchan_ctrl_pkg::RSP_ACK;
         default:                        rsp_kind_o = mchan_ctrl_pkg::RSP_NONE;
      endcase
   end

   // ******************************************************************
   // State, transfer ID and arbiter barrier
   // ******************************************************************

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         state_q   <= mchan_ctrl_pkg::IDLE;
         sid_q     <= '0;
         barrier_q <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         if (trans_alloc_req_o && trans_alloc_gnt_i)
            sid_q <= trans_alloc_ret_i;
         if (cmd_req_o)
            barrier_q <= 1'b1;   // Wait until arbitrated
         else if (arb_match)
            barrier_q <= 1'b0;
      end
   end

   always_comb
   begin
      cmd_o     = cmd_fields_i;
      cmd_o.sid = sid_q;
   end

   assign sid_o = sid_q;

   // A queue is never pushed while it refuses entries
   assert property (@(posedge clk_i) disable iff (!rst_ni)
      (cmd_req_o |-> cmd_gnt_i) and (tcdm_req_o |-> tcdm_gnt_i) and (ext_req_o |-> ext_gnt_i));

   // Each target grant serves exactly one kind of request
   assert property (@(posedge clk_i) disable iff (!rst_ni)
      targ_gnt_o |-> $onehot({cmd_req_o, tcdm_req_o, ext_req_o, trans_alloc_req_o,
                              op_i == mchan_ctrl_pkg::OP_STATUS_RD,
                              op_i == mchan_ctrl_pkg::OP_CLEAR_WR}));

endmodule

// ==== hw/ctrl_response.sv ====
// ********************************************************************
// Result stage: builds the target response one cycle after a grant
// and keeps the ID of the requesting PE
// ********************************************************************

`timescale 1ns/1ps

module ctrl_response
(
   input  logic                                      clk_i,
   input  logic                                      rst_ni,
   input  logic                                      gnt_i,
   input  logic [mchan_ctrl_pkg::PE_ID_WIDTH-1:0]    pe_id_i,
   input  mchan_ctrl_pkg::rsp_kind_e                 rsp_kind_i,
   input  logic [mchan_ctrl_pkg::SID_WIDTH-1:0]      sid_i,
   input  logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0]   trans_status_i,
   input  logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0]   trans_alloc_status_i,
   output mchan_ctrl_pkg::targ_rsp_t                 targ_rsp_o
);

   logic [mchan_ctrl_pkg::PE_ID_WIDTH-1:0] pe_id_q;

   always_ff @(posedge clk_i, negedge rst_ni)
   begin
      if (!rst_ni)
         pe_id_q <= '0;
      else if (gnt_i)
         pe_id_q <= pe_id_i;   // Requester of the granted access
   end

   // ******************************************************************
   // Read data mux
   // ******************************************************************

   always_comb
   begin
      targ_rsp_o         = '0;
      targ_rsp_o.r_valid = (rsp_kind_i != mchan_ctrl_pkg::RSP_NONE);
      targ_rsp_o.r_id    = pe_id_q;
      case (rsp_kind_i)
         mchan_ctrl_pkg::RSP_SID:
         begin
            targ_rsp_o.r_data[mchan_ctrl_pkg::SID_WIDTH-1:0] = sid_i;
         end
         mchan_ctrl_pkg::RSP_STATUS:
         begin
            // Both bitmaps sampled in the response cycle
            targ_rsp_o.r_data[mchan_ctrl_pkg::NB_TRANSFERS-1:0] = trans_status_i;
            targ_rsp_o.r_data[mchan_ctrl_pkg::ALLOC_STATUS_LSB +: mchan_ctrl_pkg::NB_TRANSFERS]
               = trans_alloc_status_i;
         end
         default:
         begin
            targ_rsp_o.r_data = '0;   // Ack carries no data
         end
      endcase
   end

   // Every response answers the grant of the previous cycle
   assert property (@(posedge clk_i) disable iff (!rst_ni)
      targ_rsp_o.r_valid |-> (rsp_kind_i != mchan_ctrl_pkg::RSP_NONE) && $past(gnt_i));

endmodule

// ==== hw/mchan_ctrl_top.sv ====
// ********************************************************************
// Programming front end of the cluster DMA: connects the target port
// through decode, sequencer and response stages to the queues
// ********************************************************************

`timescale 1ns/1ps

module mchan_ctrl_top
(
   input  logic                                       clk_i,
   input  logic                                       rst_ni,

   input  mchan_ctrl_pkg::targ_req_t                  targ_req_i,
   output logic                                       targ_gnt_o,
   output mchan_ctrl_pkg::targ_rsp_t                  targ_rsp_o,

   input  logic                                       cmd_gnt_i,
   output logic                                       cmd_req_o,
   output mchan_ctrl_pkg::cmd_t                       cmd_o,

   input  logic                                       tcdm_gnt_i,
   output logic                                       tcdm_req_o,
   output logic [mchan_ctrl_pkg::TCDM_ADD_WIDTH-1:0]  tcdm_add_o,

   input  logic                                       ext_gnt_i,
   output logic                                       ext_req_o,
   output logic [mchan_ctrl_pkg::EXT_ADD_WIDTH-1:0]   ext_add_o,

   output logic                                       trans_alloc_req_o,
   input  logic                                       trans_alloc_gnt_i,
   input  logic [mchan_ctrl_pkg::SID_WIDTH-1:0]       trans_alloc_ret_i,
   output logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0]    trans_alloc_clr_o,
   input  logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0]    trans_alloc_status_i,
   input  logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0]    trans_status_i,

   input  logic                                       arb_req_i,
   input  logic                                       arb_gnt_i,
   input  logic [mchan_ctrl_pkg::SID_WIDTH-1:0]       arb_sid_i,

   output logic                                       busy_o
);

   mchan_ctrl_pkg::ctrl_op_e                 op;
   mchan_ctrl_pkg::cmd_t                     cmd_fields;
   mchan_ctrl_pkg::rsp_kind_e                rsp_kind;
   logic [mchan_ctrl_pkg::NB_TRANSFERS-1:0]  clr_mask;
   logic [mchan_ctrl_pkg::SID_WIDTH-1:0]     sid;

   // Address words go straight to their queues
   assign tcdm_add_o = targ_req_i.data[mchan_ctrl_pkg::TCDM_ADD_WIDTH-1:0];
   assign ext_add_o  = targ_req_i.data[mchan_ctrl_pkg::EXT_ADD_WIDTH-1:0];

   ctrl_decode i_decode (
      .targ_req_i   (targ_req_i),
      .op_o         (op),
      .cmd_fields_o (cmd_fields),
      .clr_mask_o   (clr_mask)
   );

   ctrl_sequencer i_sequencer (
      .clk_i             (clk_i),
      .rst_ni            (rst_ni),
      .op_i              (op),
      .req_i             (targ_req_i.req),
      .cmd_fields_i      (cmd_fields),
      .clr_mask_i        (clr_mask),
      .cmd_gnt_i         (cmd_gnt_i),
      .cmd_req_o         (cmd_req_o),
      .tcdm_gnt_i        (tcdm_gnt_i),
      .tcdm_req_o        (tcdm_req_o),
      .ext_gnt_i         (ext_gnt_i),
      .ext_req_o         (ext_req_o),
      .trans_alloc_req_o (trans_alloc_req_o),
      .trans_alloc_gnt_i (trans_alloc_gnt_i),
      .trans_alloc_ret_i (trans_alloc_ret_i),
      .trans_alloc_clr_o (trans_alloc_clr_o),
      .trans_status_i    (trans_status_i),
      .arb_req_i         (arb_req_i),
      .arb_gnt_i         (arb_gnt_i),
      .arb_sid_i         (arb_sid_i),
      .targ_gnt_o        (targ_gnt_o),
      .rsp_kind_o        (rsp_kind),
      .sid_o             (sid),
      .cmd_o             (cmd_o),
      .busy_o            (busy_o)
   );

   ctrl_response i_response (
      .clk_i                (clk_i),
      .rst_ni               (rst_ni),
      .gnt_i                (targ_gnt_o),
      .pe_id_i              (targ_req_i.id),
      .rsp_kind_i           (rsp_kind),
      .sid_i                (sid),
      .trans_status_i       (trans_status_i),
      .trans_alloc_status_i (trans_alloc_status_i),
      .targ_rsp_o           (targ_rsp_o)
   );

endmodule

// ==== tests/tb_mchan_ctrl.sv ====
// ********************************************************************
// Directed testbench of the DMA programming front end: status, clear,
// 1D programming, queue back-pressure and the completion wait
// ********************************************************************

`timescale 1ns/1ps

module tb_mchan_ctrl;

   localparam int unsigned CLK_PERIOD      = 8;
   localparam int unsigned NUM_TESTS       = 5;
   localparam int unsigned CYCLES_PER_TEST = 400;
   localparam int unsigned WAIT_LIMIT      = 20;   // Cycles a handshake may take
   localparam int unsigned NB              = mchan_ctrl_pkg::NB_TRANSFERS;
   localparam int unsigned SW              = mchan_ctrl_pkg::SID_WIDTH;

   logic                                               clk_i;
   logic                                               rst_ni;
   mchan_ctrl_pkg::targ_req_t                          targ_req;
   logic                                               targ_gnt;
   mchan_ctrl_pkg::targ_rsp_t                          targ_rsp;
   logic                                               cmd_gnt, cmd_req;
   mchan_ctrl_pkg::cmd_t                               cmd;
   logic                                               tcdm_gnt, tcdm_req;
   logic [mchan_ctrl_pkg::TCDM_ADD_WIDTH-1:0]          tcdm_add;
   logic                                               ext_gnt, ext_req;
   logic [mchan_ctrl_pkg::EXT_ADD_WIDTH-1:0]           ext_add;
   logic                                               alloc_req, alloc_gnt;
   logic [SW-1:0]                                      alloc_ret;
   logic [NB-1:0]                                      alloc_clr, alloc_status, trans_status;
   logic                                               arb_req, arb_gnt;
   logic [SW-1:0]                                      arb_sid;
   logic                                               busy;
   integer                                             seed;
   int unsigned                                        errors;
   int unsigned                                        tests_run;

   mchan_ctrl_top i_dut (
      .clk_i                (clk_i),
      .rst_ni               (rst_ni),
      .targ_req_i           (targ_req),
      .targ_gnt_o           (targ_gnt),
      .targ_rsp_o           (targ_rsp),
      .cmd_gnt_i            (cmd_gnt),
      .cmd_req_o            (cmd_req),
      .cmd_o                (cmd),
      .tcdm_gnt_i           (tcdm_gnt),
      .tcdm_req_o           (tcdm_req),
      .tcdm_add_o           (tcdm_add),
      .ext_gnt_i            (ext_gnt),
      .ext_req_o            (ext_req),
      .ext_add_o            (ext_add),
      .trans_alloc_req_o    (alloc_req),
      .trans_alloc_gnt_i    (alloc_gnt),
      .trans_alloc_ret_i    (alloc_ret),
      .trans_alloc_clr_o    (alloc_clr),
      .trans_alloc_status_i (alloc_status),
      .trans_status_i       (trans_status),
      .arb_req_i            (arb_req),
      .arb_gnt_i            (arb_gnt),
      .arb_sid_i            (arb_sid),
      .busy_o               (busy)
   );

   initial
   begin
      clk_i = 1'b0;
      forever
         #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   // ******************************************************************
   // Reporting and target port handshakes
   // ******************************************************************

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      errors++;
      $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("Failure at %0t: %s", $time, what);
   endtask

   // Raises a request on the falling edge and lets outputs settle for 1 ns
   task automatic drive_request(input logic wen,
                                input logic [mchan_ctrl_pkg::OFFSET_WIDTH-1:0] offset,
                                input logic [31:0] data);
      logic [31:0] upper;
      logic [31:0] id;
      @(negedge clk_i);
      upper         = $random(seed);
      id            = $random(seed);
      targ_req.req  = 1'b1;
      targ_req.wen  = wen;
      targ_req.add  = {upper[31:mchan_ctrl_pkg::OFFSET_WIDTH], offset};   // Upper bits ignored
      targ_req.data = data;
      targ_req.id   = id[mchan_ctrl_pkg::PE_ID_WIDTH-1:0];
      #1;
   endtask

   task automatic await_grant(output int unsigned waited);
      waited = 0;
      while (targ_gnt !== 1'b1 && waited < WAIT_LIMIT)
      begin
         @(negedge clk_i);
         #1;
         waited++;
      end
      if (targ_gnt !== 1'b1)
         report_failure("request was never granted");
   endtask

   // Drops the request and checks the response to the last grant
   task automatic check_response(input logic [31:0] exp_data);
      logic [mchan_ctrl_pkg::PE_ID_WIDTH-1:0] exp_id;
      exp_id = targ_req.id;
      @(negedge clk_i);
      targ_req.req = 1'b0;
      #1;
      if (targ_rsp.r_valid !== 1'b1)
         report_failure("no r_valid one cycle after the grant");
      if (targ_rsp.r_data !== exp_data)
         report_mismatch("r_data", targ_rsp.r_data, exp_data);
      if (targ_rsp.r_id !== exp_id)
         report_mismatch("r_id", targ_rsp.r_id, exp_id);
   endtask

   task automatic wait_idle();
      int unsigned waited;
      waited = 0;
      #1;
      while (busy !== 1'b0 && waited < WAIT_LIMIT)
      begin
         @(negedge clk_i);
         #1;
         waited++;
      end
      if (busy !== 1'b0)
         report_failure("busy_o never dropped after the transfer completed");
   endtask

   task automatic arbiter_handshake(input logic [SW-1:0] sid);
      @(negedge clk_i);
      arb_req = 1'b1;
      arb_gnt = 1'b1;
      arb_sid = sid;
      @(negedge clk_i);
      arb_req = 1'b0;
      arb_gnt = 1'b0;
   endtask

   // ******************************************************************
   // Directed tests
   // ******************************************************************

   task automatic test_status_read();
      logic [31:0] exp;
      int unsigned waited;
      @(negedge clk_i);
      trans_status = $random(seed);
      alloc_status = $random(seed);
      drive_request(1'b0, mchan_ctrl_pkg::STATUS_OFFSET, $random(seed));
      await_grant(waited);
      if (waited != 0)
         report_failure("status read not granted in the request cycle");
      if (targ_rsp.r_valid !== 1'b0)
         report_mismatch("r_valid", targ_rsp.r_valid, 0);
      exp = '0;
      exp[NB-1:0] = trans_status;
      exp[mchan_ctrl_pkg::ALLOC_STATUS_LSB +: NB] = alloc_status;
      check_response(exp);
   endtask

   task automatic test_clear_write();
      logic [31:0] word;
      int unsigned waited;
      word = $random(seed);
      drive_request(1'b1, mchan_ctrl_pkg::STATUS_OFFSET, word);
      await_grant(waited);
      if (waited != 0)
         report_failure("clear write not granted in the request cycle");
      if (alloc_clr !== word[NB-1:0])
         report_mismatch("trans_alloc_clr_o", alloc_clr, word[NB-1:0]);
      check_response(32'h0);   // Ack only
      if (alloc_clr !== '0)
         report_mismatch("trans_alloc_clr_o", alloc_clr, 0);
   endtask

   // ID read and the three writes; hold keeps the command queue full
   task automatic program_transfer(input int unsigned hold, output logic [SW-1:0] sid);
      mchan_ctrl_pkg::cmd_t exp_cmd;
      logic [31:0]          word;
      int unsigned          waited;
      int unsigned          i;
      @(negedge clk_i);
      cmd_gnt      = (hold == 0);
      trans_status = '0;
      alloc_ret    = $random(seed);
      sid          = alloc_ret;
      drive_request(1'b0, mchan_ctrl_pkg::CMD_OFFSET, 32'h0);
      await_grant(waited);
      if (alloc_req !== 1'b1)
         report_mismatch("trans_alloc_req_o", alloc_req, 1);
      check_response(32'(sid));

      word = $random(seed);
      if (word[mchan_ctrl_pkg::LEN_WIDTH-1:0] == '0)
         word[0] = 1'b1;
      exp_cmd     = '0;
      exp_cmd.len = word[mchan_ctrl_pkg::LEN_WIDTH-1:0] - 1;
      exp_cmd.opc = mchan_ctrl_pkg::mchan_opc_e'(word[mchan_ctrl_pkg::OPC_BIT]);
      exp_cmd.inc = word[mchan_ctrl_pkg::INC_BIT];
      exp_cmd.ele = word[mchan_ctrl_pkg::ELE_BIT];
      exp_cmd.ile = word[mchan_ctrl_pkg::ILE_BIT];
      exp_cmd.ble = word[mchan_ctrl_pkg::BLE_BIT];
      exp_cmd.sid = sid;
      drive_request(1'b1, mchan_ctrl_pkg::CMD_OFFSET, word);
      for (i = 0; i < hold; i++)
      begin
         if (targ_gnt !== 1'b0)
            report_mismatch("targ_gnt_o", targ_gnt, 0);
         if (cmd_req !== 1'b0)
            report_mismatch("cmd_req_o", cmd_req, 0);
         @(negedge clk_i);
         cmd_gnt = (i == hold - 1);   // Queue frees up at the end
         #1;
      end
      await_grant(waited);
      if (cmd_req !== 1'b1)
         report_mismatch("cmd_req_o", cmd_req, 1);
      if (cmd !== exp_cmd)
         report_mismatch("cmd_o", cmd, exp_cmd);
      check_response(32'h0);

      word = $random(seed);
      drive_request(1'b1, mchan_ctrl_pkg::CMD_OFFSET, word);
      await_grant(waited);
      if (tcdm_req !== 1'b1)
         report_mismatch("tcdm_req_o", tcdm_req, 1);
      if (tcdm_add !== word[mchan_ctrl_pkg::TCDM_ADD_WIDTH-1:0])
         report_mismatch("tcdm_add_o", tcdm_add, word[mchan_ctrl_pkg::TCDM_ADD_WIDTH-1:0]);
      check_response(32'h0);

      word = $random(seed);
      drive_request(1'b1, mchan_ctrl_pkg::CMD_OFFSET, word);
      await_grant(waited);
      if (ext_req !== 1'b1)
         report_mismatch("ext_req_o", ext_req, 1);
      if (ext_add !== word[mchan_ctrl_pkg::EXT_ADD_WIDTH-1:0])
         report_mismatch("ext_add_o", ext_add, word[mchan_ctrl_pkg::EXT_ADD_WIDTH-1:0]);
      check_response(32'h0);
      if (busy !== 1'b1)
         report_mismatch("busy_o", busy, 1);
   endtask

   task automatic test_full_transfer(input int unsigned hold);
      logic [SW-1:0] sid;
      program_transfer(hold, sid);
      arbiter_handshake(sid);
      trans_status[sid] = 1'b1;
      wait_idle();
   endtask

   task automatic test_completion_wait();
      logic [SW-1:0] sid;
      program_transfer(0, sid);
      arbiter_handshake(sid + 1'b1);   // Another transfer wins
      trans_status = '1;               // Status reports done before arbitration
      repeat (5)
      begin
         @(negedge clk_i);
         #1;
         if (busy !== 1'b1)
            report_failure("busy_o dropped before the matching arbiter handshake");
      end
      @(negedge clk_i);
      trans_status[sid] = 1'b0;
      arbiter_handshake(sid);
      repeat (5)
      begin
         @(negedge clk_i);
         #1;
         if (busy !== 1'b1)
            report_failure("busy_o dropped before the transfer status bit was set");
      end
      @(negedge clk_i);
      trans_status[sid] = 1'b1;
      wait_idle();
      test_status_read();
   endtask

   // ******************************************************************
   // Sequence and watchdog
   // ******************************************************************

   initial
   begin
      seed         = 32'h700f;
      errors       = 0;
      tests_run    = 0;
      rst_ni       = 1'b0;
      targ_req     = '0;
      cmd_gnt      = 1'b1;
      tcdm_gnt     = 1'b1;
      ext_gnt      = 1'b1;
      alloc_gnt    = 1'b1;
      alloc_ret    = '0;
      alloc_status = '0;
      trans_status = '0;
      arb_req      = 1'b0;
      arb_gnt      = 1'b0;
      arb_sid      = '0;
      repeat (16) @(posedge clk_i);
      @(negedge clk_i);
      rst_ni = 1'b1;
      #1;
      if (busy !== 1'b0)
         report_mismatch("busy_o", busy, 0);
      if (targ_rsp.r_valid !== 1'b0)
         report_mismatch("r_valid", targ_rsp.r_valid, 0);

      test_status_read();
      tests_run++;
      test_clear_write();
      tests_run++;
      test_full_transfer(0);
      tests_run++;
      test_full_transfer(6);   // Command queue full for a while
      tests_run++;
      test_completion_wait();
      tests_run++;

      $display("Summary: %0d tests run, %0d errors", tests_run, errors);
      if (errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

   initial
   begin
      #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
      $display("Watchdog expired before the tests completed, %0d errors so far", errors);
      $display("Checks failed");
      $finish;
   end

endmodule

// ==== list.f ====
hw/mchan_ctrl_pkg.sv
hw/ctrl_decode.sv
hw/ctrl_sequencer.sv
hw/ctrl_response.sv
hw/mchan_ctrl_top.sv
tests/tb_mchan_ctrl.sv

// ==== Bender.yml ====
package:
  name: mchan_ctrl

sources:
  - hw/mchan_ctrl_pkg.sv
  - hw/ctrl_decode.sv
  - hw/ctrl_sequencer.sv
  - hw/ctrl_response.sv
  - hw/mchan_ctrl_top.sv
  - target: test
    files:
      - tests/tb_mchan_ctrl.sv
